// File: filelist.f
mini_mcu_pkg.sv
system_bus.sv
memory_subsystem.sv
ao_peripheral_subsystem.sv
core_v_mini_mcu.sv
tb_core_v_mini_mcu.sv

// File: Makefile
# Verilator build and run of the fabric testbench
# any variable below can be set on the command line

VERILATOR ?= verilator
TOP       ?= tb_core_v_mini_mcu
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing -j $(JOBS)

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR JOBS VFLAGS"

$(SIM): $(FILELIST) $(wildcard *.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator exits non-zero on any failure
test: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_core_v_mini_mcu.sv
// ********************
// self-checking testbench for the fabric top level, two OBI masters
// against a shadow model of RAM and always-on registers
// ********************
`timescale 1ns/100ps
`default_nettype none

module tb_core_v_mini_mcu;

  localparam int unsigned NUM_BANKS       = 2;
  localparam int unsigned BANK_WORDS      = 256;
  localparam int unsigned RAM_WORDS       = NUM_BANKS * BANK_WORDS;
  localparam logic [31:0] RAM_BYTES       = 32'(RAM_WORDS * 4);
  localparam int          N_RANDOM        = 60;
  localparam int          N_DIRECTED      = 23;
  localparam int          TOTAL_XFERS     = RAM_WORDS + 2 * N_RANDOM + N_DIRECTED;
  localparam int          WATCHDOG_CYCLES = TOTAL_XFERS * 8 + 100;

  logic                    clk_i = 1'b0;
  logic                    rst_n_i;
  logic                    boot_sel;
  mini_mcu_pkg::obi_req_t  mreq  [2];
  mini_mcu_pkg::obi_resp_t mresp [2];
  logic [31:0]             exit_value;
  logic                    exit_valid;

  // shadow state updated in grant order
  logic [31:0]          shadow_ram [RAM_WORDS];
  logic [NUM_BANKS-1:0] shadow_bank_en = '1;
  logic [31:0]          shadow_scratch = 32'h0;
  logic [31:0]          shadow_exit_value = 32'h0;
  logic                 shadow_exit_valid = 1'b0;

  // response tracking per master
  logic [1:0]  due = 2'b00;
  logic [1:0]  exp_err = 2'b00;
  logic [31:0] exp_rdata [2];
  int          next_winner = 0;
  int          grants = 0;
  int          issued = 0;

  core_v_mini_mcu #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) dut (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .boot_select_i    (boot_sel),
    .core_data_req_i  (mreq[0]),
    .core_data_resp_o (mresp[0]),
    .ext_master_req_i (mreq[1]),
    .ext_master_resp_o(mresp[1]),
    .exit_value_o     (exit_value),
    .exit_valid_o     (exit_valid)
  );

  always #2 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped after an error");
  endtask

  function automatic string resp_name(input int m);
    return (m == 0) ? "core_data_resp_o" : "ext_master_resp_o";
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
  endfunction

  function automatic logic [31:0] ao_addr(input logic [11:0] offset);
    return {mini_mcu_pkg::AO_BASE[31:12], offset};
  endfunction

  function automatic logic is_ao(input logic [31:0] addr);
    return addr[31:12] == mini_mcu_pkg::AO_BASE[31:12];
  endfunction

  // reference model returning {err, rdata}
  function automatic logic [32:0] expected_resp(input mini_mcu_pkg::obi_req_t r);
    int unsigned word;
    logic [31:0] data;
    data = 32'h0;
    if (r.addr < RAM_BYTES) begin
      word = 32'(r.addr[31:2]);
      if (!r.we && shadow_bank_en[word / BANK_WORDS]) begin
        data = shadow_ram[word];
      end
      return {1'b0, data};
    end
    if (!is_ao(r.addr)) begin
      return {1'b1, 32'h0};
    end
    if (!r.we) begin
      case (r.addr[11:0])
        mini_mcu_pkg::AO_EXIT_VALID_OFFSET:  data = {31'h0, shadow_exit_valid};
        mini_mcu_pkg::AO_EXIT_VALUE_OFFSET:  data = shadow_exit_value;
        mini_mcu_pkg::AO_SCRATCH_OFFSET:     data = shadow_scratch;
        mini_mcu_pkg::AO_BANK_EN_OFFSET:     data = 32'(shadow_bank_en);
        mini_mcu_pkg::AO_BOOT_SELECT_OFFSET: data = {31'h0, boot_sel};
        default:                             data = 32'h0;
      endcase
    end
    return {1'b0, data};
  endfunction

  function automatic void apply_write(input mini_mcu_pkg::obi_req_t r);
    int unsigned word;
    if (!r.we) begin
      return;
    end
    if (r.addr < RAM_BYTES) begin
      word = 32'(r.addr[31:2]);
      // a disabled bank drops the write
      if (shadow_bank_en[word / BANK_WORDS]) begin
        shadow_ram[word] = merge_lanes(shadow_ram[word], r.wdata, r.be);
      end
    end else if (is_ao(r.addr)) begin
      case (r.addr[11:0])
        mini_mcu_pkg::AO_EXIT_VALID_OFFSET: shadow_exit_valid = r.wdata[0];
        mini_mcu_pkg::AO_EXIT_VALUE_OFFSET: begin
          shadow_exit_value = merge_lanes(shadow_exit_value, r.wdata, r.be);
        end
        mini_mcu_pkg::AO_SCRATCH_OFFSET: begin
          shadow_scratch = merge_lanes(shadow_scratch, r.wdata, r.be);
        end
        mini_mcu_pkg::AO_BANK_EN_OFFSET: shadow_bank_en = r.wdata[NUM_BANKS-1:0];
        default: ;
      endcase
    end
  endfunction

  // compare process samples outputs at the falling edge
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      for (int m = 0; m < 2; m++) begin
        if (due[m]) begin
          assert (mresp[m].rvalid)
            else abort_run($sformatf("%s: no rvalid one cycle after gnt", resp_name(m)));
          assert (mresp[m].err == exp_err[m])
            else abort_run($sformatf("** Error: %s.err = 0x%0h, expected 0x%0h",
                                     resp_name(m), mresp[m].err, exp_err[m]));
          assert (mresp[m].rdata == exp_rdata[m])
            else abort_run($sformatf("** Error: %s.rdata = 0x%08h, expected 0x%08h",
                                     resp_name(m), mresp[m].rdata, exp_rdata[m]));
        end else begin
          assert (!mresp[m].rvalid)
            else abort_run($sformatf("%s: rvalid without a preceding gnt", resp_name(m)));
        end
        due[m] = mresp[m].gnt;
        if (mresp[m].gnt) begin
          {exp_err[m], exp_rdata[m]} = expected_resp(mreq[m]);
          apply_write(mreq[m]);
          grants++;
        end
      end
      if (mreq[0].req && mreq[1].req) begin
        assert (mresp[next_winner].gnt && !mresp[1 - next_winner].gnt)
          else abort_run($sformatf("** Error: %s.gnt = 0x%0h in a contested cycle, expected 0x1",
                                   resp_name(next_winner), mresp[next_winner].gnt));
        next_winner = 1 - next_winner;
      end else begin
        for (int m = 0; m < 2; m++) begin
          assert (mresp[m].gnt == mreq[m].req)
            else abort_run($sformatf("** Error: %s.gnt = 0x%0h, expected 0x%0h",
                                     resp_name(m), mresp[m].gnt, mreq[m].req));
        end
      end
    end
  end

  function automatic mini_mcu_pkg::obi_req_t make_req(input logic we, input logic [31:0] addr,
                                                      input logic [3:0] be,
                                                      input logic [31:0] wdata);
    mini_mcu_pkg::obi_req_t r;
    r.req   = 1'b1;
    r.we    = we;
    r.be    = be;
    r.addr  = addr;
    r.wdata = wdata;
    return r;
  endfunction

  // a loser is granted after at most one cycle
  task automatic wait_grant(input int m);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!mresp[m].gnt) begin
      waited++;
      if (waited > 1) begin
        abort_run($sformatf("%s: request not granted within one cycle", resp_name(m)));
      end
      @(negedge clk_i);
    end
    issued++;
  endtask

  task automatic core_xfer(input mini_mcu_pkg::obi_req_t r, input bit hold);
    @(posedge clk_i);
    mreq[0] <= r;
    wait_grant(0);
    if (!hold) begin
      @(posedge clk_i);
      mreq[0].req <= 1'b0;
    end
  endtask

  task automatic ext_xfer(input mini_mcu_pkg::obi_req_t r, input bit hold);
    @(posedge clk_i);
    mreq[1] <= r;
    wait_grant(1);
    if (!hold) begin
      @(posedge clk_i);
      mreq[1].req <= 1'b0;
    end
  endtask

  task automatic xfer(input int m, input mini_mcu_pkg::obi_req_t r, input bit hold);
    if (m == 0) begin
      core_xfer(r, hold);
    end else begin
      ext_xfer(r, hold);
    end
  endtask

  task automatic single(input logic we, input logic [31:0] addr, input logic [3:0] be,
                        input logic [31:0] wdata);
    core_xfer(make_req(we, addr, be, wdata), 1'b0);
  endtask

  task automatic fill_bank(input int m);
    logic [31:0] addr;
    for (int i = 0; i < int'(BANK_WORDS); i++) begin
      addr = 32'((m * int'(BANK_WORDS) + i) * 4);
      xfer(m, make_req(1'b1, addr, mini_mcu_pkg::BE_ALL, fill_word(addr)),
           i != int'(BANK_WORDS) - 1);
    end
  endtask

  task automatic random_traffic(input int m, input int n);
    int unsigned word;
    logic        we;
    logic [3:0]  be;
    for (int i = 0; i < n; i++) begin
      word = $urandom % RAM_WORDS;
      we   = 1'($urandom % 2);
      be   = 4'($urandom % 16);
      xfer(m, make_req(we, 32'(word * 4), be, $urandom), i != n - 1);
    end
  endtask

  task automatic check_exit_outputs();
    @(negedge clk_i);
    assert (exit_valid == shadow_exit_valid)
      else abort_run($sformatf("** Error: exit_valid_o = 0x%0h, expected 0x%0h",
                               exit_valid, shadow_exit_valid));
    assert (exit_value == shadow_exit_value)
      else abort_run($sformatf("** Error: exit_value_o = 0x%08h, expected 0x%08h",
                               exit_value, shadow_exit_value));
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    abort_run("watchdog expired before the test sequence finished");
  end

  initial begin
    void'($urandom(11333));
    rst_n_i  <= 1'b0;
    boot_sel <= 1'b1;
    mreq[0]  <= mini_mcu_pkg::OBI_REQ_IDLE;
    mreq[1]  <= mini_mcu_pkg::OBI_REQ_IDLE;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    for (int m = 0; m < 2; m++) begin
      assert (!mresp[m].gnt && !mresp[m].rvalid && !mresp[m].err)
        else abort_run($sformatf("%s: handshake outputs not idle in reset", resp_name(m)));
    end
    check_exit_outputs();
    @(posedge clk_i);
    rst_n_i <= 1'b1;

    // both masters contend from the first cycle with master 0 first
    fork
      fill_bank(0);
      fill_bank(1);
    join

    // bank 1 disabled and enabled again
    single(1'b1, ao_addr(mini_mcu_pkg::AO_BANK_EN_OFFSET), 4'hF, 32'h1);
    single(1'b0, ao_addr(mini_mcu_pkg::AO_BANK_EN_OFFSET), 4'hF, 32'h0);
    single(1'b0, 32'(BANK_WORDS * 4 + 12), 4'hF, 32'h0);
    single(1'b1, 32'(BANK_WORDS * 4 + 12), 4'hF, 32'hDEAD_BEEF);
    single(1'b0, 32'h0000_0010, 4'hF, 32'h0);
    single(1'b1, ao_addr(mini_mcu_pkg::AO_BANK_EN_OFFSET), 4'hF, 32'h3);
    single(1'b0, 32'(BANK_WORDS * 4 + 12), 4'hF, 32'h0);

    // unmapped accesses and reads of what they could alias
    single(1'b1, RAM_BYTES, 4'hF, 32'hBAD0_0001);
    single(1'b0, RAM_BYTES + 32'h4, 4'hF, 32'h0);
    single(1'b1, mini_mcu_pkg::AO_BASE + 32'h1008, 4'hF, 32'hBAD0_0002);
    single(1'b0, 32'h1FFF_FFFC, 4'hF, 32'h0);
    single(1'b0, 32'h0000_0000, 4'hF, 32'h0);
    single(1'b0, ao_addr(mini_mcu_pkg::AO_SCRATCH_OFFSET), 4'hF, 32'h0);

    // always-on registers
    single(1'b1, ao_addr(mini_mcu_pkg::AO_SCRATCH_OFFSET), 4'hF, 32'h1234_5678);
    single(1'b1, ao_addr(mini_mcu_pkg::AO_SCRATCH_OFFSET), 4'b0101, 32'hAABB_CCDD);
    single(1'b0, ao_addr(mini_mcu_pkg::AO_SCRATCH_OFFSET), 4'hF, 32'h0);
    single(1'b0, ao_addr(12'h020), 4'hF, 32'h0);
    @(posedge clk_i);
    boot_sel <= 1'b0;
    single(1'b0, ao_addr(mini_mcu_pkg::AO_BOOT_SELECT_OFFSET), 4'hF, 32'h0);
    @(posedge clk_i);
    boot_sel <= 1'b1;
    single(1'b0, ao_addr(mini_mcu_pkg::AO_BOOT_SELECT_OFFSET), 4'hF, 32'h0);
    single(1'b1, ao_addr(mini_mcu_pkg::AO_EXIT_VALUE_OFFSET), 4'hF, 32'hC0FF_EE01);
    single(1'b1, ao_addr(mini_mcu_pkg::AO_EXIT_VALID_OFFSET), 4'hF, 32'h1);
    check_exit_outputs();
    single(1'b0, ao_addr(mini_mcu_pkg::AO_EXIT_VALUE_OFFSET), 4'hF, 32'h0);
    single(1'b1, ao_addr(mini_mcu_pkg::AO_EXIT_VALID_OFFSET), 4'hF, 32'h0);
    check_exit_outputs();

    fork
      random_traffic(0, N_RANDOM);
      random_traffic(1, N_RANDOM);
    join

    repeat (3) @(posedge clk_i);
    if (grants == issued && due == 2'b00) begin
      $display(">>> PASS");
      $finish;
    end else begin
      abort_run($sformatf("%0d grants seen for %0d issued transfers", grants, issued));
    end
  end

endmodule

`default_nettype wire

// File: core_v_mini_mcu.sv
// ********************
// fabric top level: core data port and external master share the bus
// to banked RAM and the always-on page
// ********************
`timescale 1ns/100ps
`default_nettype none

module core_v_mini_mcu #(
  parameter int unsigned NUM_BANKS  = 2,
  parameter int unsigned BANK_WORDS = 256
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    boot_select_i,
  input  mini_mcu_pkg::obi_req_t  core_data_req_i,
  output mini_mcu_pkg::obi_resp_t core_data_resp_o,
  input  mini_mcu_pkg::obi_req_t  ext_master_req_i,
  output mini_mcu_pkg::obi_resp_t ext_master_resp_o,
  output logic [31:0]             exit_value_o,
  output logic                    exit_valid_o
);

  // bus masters, index 0 core data, index 1 external
  mini_mcu_pkg::obi_req_t  [mini_mcu_pkg::NUM_MASTERS-1:0] master_req;
  mini_mcu_pkg::obi_resp_t [mini_mcu_pkg::NUM_MASTERS-1:0] master_resp;

  // slave side
  mini_mcu_pkg::obi_req_t  ram_slave_req;
  mini_mcu_pkg::obi_resp_t ram_slave_resp;
  mini_mcu_pkg::obi_req_t  ao_slave_req;
  mini_mcu_pkg::obi_resp_t ao_slave_resp;

  logic [NUM_BANKS-1:0] bank_en;

  assign master_req[0]     = core_data_req_i;
  assign master_req[1]     = ext_master_req_i;
  assign core_data_resp_o  = master_resp[0];
  assign ext_master_resp_o = master_resp[1];

  system_bus #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) system_bus_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .master_req_i (master_req),
    .master_resp_o(master_resp),
    .ram_req_o    (ram_slave_req),
    .ram_resp_i   (ram_slave_resp),
    .ao_req_o     (ao_slave_req),
    .ao_resp_i    (ao_slave_resp)
  );

  memory_subsystem #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) memory_subsystem_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .ram_req_i (ram_slave_req),
    .ram_resp_o(ram_slave_resp),
    .bank_en_i (bank_en)
  );

  ao_peripheral_subsystem #(
    .NUM_BANKS(NUM_BANKS)
  ) ao_peripheral_subsystem_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ao_req_i     (ao_slave_req),
    .ao_resp_o    (ao_slave_resp),
    .boot_select_i(boot_select_i),
    .bank_en_o    (bank_en),
    .exit_value_o (exit_value_o),
    .exit_valid_o (exit_valid_o)
  );

endmodule

`default_nettype wire

// File: ao_peripheral_subsystem.sv
// ********************
// always-on register page: exit status, scratch, bank enables
// and boot-select readback
// ********************
`timescale 1ns/100ps
`default_nettype none

module ao_peripheral_subsystem #(
  parameter int unsigned NUM_BANKS = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  mini_mcu_pkg::obi_req_t  ao_req_i,
  output mini_mcu_pkg::obi_resp_t ao_resp_o,
  input  logic                    boot_select_i,
  output logic [NUM_BANKS-1:0]    bank_en_o,
  output logic [31:0]             exit_value_o,
  output logic                    exit_valid_o
);

  logic [11:0]          offset;
  logic                 wr_en;
  logic                 rd_en;
  logic [31:0]          rd_word;

  logic                 exit_valid_q;
  logic [31:0]          exit_value_q;
  logic [31:0]          scratch_q;
  logic [NUM_BANKS-1:0] bank_en_q;
  logic                 rvalid_q;
  logic [31:0]          rdata_q;

  assign offset = ao_req_i.addr[11:0];
  assign wr_en  = ao_req_i.req && ao_req_i.we;
  assign rd_en  = ao_req_i.req && !ao_req_i.we;

  // read mux gives zero for unknown offsets
  always_comb begin
    case (offset)
      mini_mcu_pkg::AO_EXIT_VALID_OFFSET:  rd_word = {31'h0, exit_valid_q};
      mini_mcu_pkg::AO_EXIT_VALUE_OFFSET:  rd_word = exit_value_q;
      mini_mcu_pkg::AO_SCRATCH_OFFSET:     rd_word = scratch_q;
      mini_mcu_pkg::AO_BANK_EN_OFFSET:     rd_word = 32'(bank_en_q);
      mini_mcu_pkg::AO_BOOT_SELECT_OFFSET: rd_word = {31'h0, boot_select_i};
      default:                             rd_word = 32'h0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= 32'h0;
      scratch_q    <= 32'h0;
      bank_en_q    <= '1;
    end else if (wr_en) begin
      case (offset)
        mini_mcu_pkg::AO_EXIT_VALID_OFFSET: begin
          exit_valid_q <= ao_req_i.wdata[0];
        end
        mini_mcu_pkg::AO_EXIT_VALUE_OFFSET: begin
          exit_value_q <= mini_mcu_pkg::be_merge(exit_value_q, ao_req_i.wdata, ao_req_i.be);
        end
        mini_mcu_pkg::AO_SCRATCH_OFFSET: begin
          scratch_q <= mini_mcu_pkg::be_merge(scratch_q, ao_req_i.wdata, ao_req_i.be);
        end
        mini_mcu_pkg::AO_BANK_EN_OFFSET: begin
          bank_en_q <= ao_req_i.wdata[NUM_BANKS-1:0];
        end
        // read-only or unmapped offset
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= ao_req_i.req;
    end
  end

  // write responses carry zero data
  always_ff @(posedge clk_i) begin
    rdata_q <= rd_en ? rd_word : 32'h0;
  end

  assign ao_resp_o.gnt    = ao_req_i.req;
  assign ao_resp_o.rvalid = rvalid_q;
  assign ao_resp_o.err    = 1'b0;
  assign ao_resp_o.rdata  = rdata_q;

  assign bank_en_o    = bank_en_q;
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

endmodule

`default_nettype wire

// File: memory_subsystem.sv
// ********************
// banked single-port RAM behind the system bus, byte-enabled writes
// and a per-bank enable from the always-on block
// ********************
`timescale 1ns/100ps
`default_nettype none

module memory_subsystem #(
  parameter int unsigned NUM_BANKS  = 2,
  parameter int unsigned BANK_WORDS = 256
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  mini_mcu_pkg::obi_req_t  ram_req_i,
  output mini_mcu_pkg::obi_resp_t ram_resp_o,
  input  logic [NUM_BANKS-1:0]    bank_en_i
);

  localparam int unsigned WORD_W = $clog2(BANK_WORDS);
  localparam int unsigned BANK_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

  logic [29:0]       word_addr;
  logic [BANK_W-1:0] bank_idx;
  logic [WORD_W-1:0] word_idx;
  logic [31:0]       bank_rdata [NUM_BANKS];

  logic              rvalid_q;
  logic              rd_en_q;
  logic [BANK_W-1:0] bank_q;

  // byte offset to word, then bank and word inside the bank
  assign word_addr = ram_req_i.addr[31:2];
  assign word_idx  = word_addr[WORD_W-1:0];
  assign bank_idx  = (NUM_BANKS > 1) ? word_addr[WORD_W +: BANK_W] : '0;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    logic [31:0] mem_q [BANK_WORDS];
    logic [31:0] rdata_q;
    logic        sel;

    assign sel = ram_req_i.req && (bank_idx == BANK_W'(b)) && bank_en_i[b];

    // disabled bank is not touched and keeps its contents
    always_ff @(posedge clk_i) begin
      if (sel) begin
        if (ram_req_i.we) begin
          mem_q[word_idx] <= mini_mcu_pkg::be_merge(mem_q[word_idx], ram_req_i.wdata,
                                                    ram_req_i.be);
        end else begin
          rdata_q <= mem_q[word_idx];
        end
      end
    end

    assign bank_rdata[b] = rdata_q;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      rd_en_q  <= 1'b0;
      bank_q   <= '0;
    end else begin
      rvalid_q <= ram_req_i.req;
      rd_en_q  <= ram_req_i.req && !ram_req_i.we && bank_en_i[bank_idx];
      bank_q   <= bank_idx;
    end
  end

  assign ram_resp_o.gnt    = ram_req_i.req;
  assign ram_resp_o.rvalid = rvalid_q;
  assign ram_resp_o.err    = 1'b0;
  // writes and disabled banks read as zero
  assign ram_resp_o.rdata  = rd_en_q ? bank_rdata[bank_q] : 32'h0;

endmodule

`default_nettype wire

// File: system_bus.sv
// ********************
// two-master OBI bus with round-robin arbitration, address decode
// to RAM, always-on page or error, and response routing
// ********************
`timescale 1ns/100ps
`default_nettype none

module system_bus #(
  parameter int unsigned NUM_BANKS  = 2,
  parameter int unsigned BANK_WORDS = 256
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  mini_mcu_pkg::obi_req_t  [mini_mcu_pkg::NUM_MASTERS-1:0] master_req_i,
  output mini_mcu_pkg::obi_resp_t [mini_mcu_pkg::NUM_MASTERS-1:0] master_resp_o,
  output mini_mcu_pkg::obi_req_t                                ram_req_o,
  input  mini_mcu_pkg::obi_resp_t                               ram_resp_i,
  output mini_mcu_pkg::obi_req_t                                ao_req_o,
  input  mini_mcu_pkg::obi_resp_t                               ao_resp_i
);

  localparam int unsigned NM    = mini_mcu_pkg::NUM_MASTERS;
  localparam int unsigned IDX_W = (NM > 1) ? $clog2(NM) : 1;
  localparam logic [31:0] RAM_BYTES = 32'(NUM_BANKS * BANK_WORDS * 4);

  logic [NM-1:0]          req_vec;
  logic                   win_valid;
  logic [IDX_W-1:0]       win_idx;
  logic                   contested;
  logic                   win_gnt;
  logic                   ram_hit;
  logic                   ao_hit;
  logic [31:0]            ram_offset;
  mini_mcu_pkg::obi_req_t win_req;

  // priority pointer and response tracking
  logic [IDX_W-1:0] prio_q;
  logic             rsp_valid_q;
  logic [IDX_W-1:0] rsp_idx_q;
  logic             rsp_err_q;
  logic             rsp_hit;
  logic [31:0]      rsp_rdata;

  always_comb begin
    for (int m = 0; m < NM; m++) begin
      req_vec[m] = master_req_i[m].req;
    end
  end

  assign contested = ($countones(req_vec) > 1);

  // search starts at the master that lost the last contested cycle
  always_comb begin
    int idx;
    win_valid = 1'b0;
    win_idx   = '0;
    for (int k = 0; k < NM; k++) begin
      idx = (int'(prio_q) + k) % NM;
      if (!win_valid && req_vec[idx]) begin
        win_valid = 1'b1;
        win_idx   = IDX_W'(idx);
      end
    end
  end

  assign win_req = win_valid ? master_req_i[win_idx] : mini_mcu_pkg::OBI_REQ_IDLE;

  // decode
  assign ram_offset = win_req.addr - mini_mcu_pkg::RAM_BASE;
  assign ram_hit    = (ram_offset < RAM_BYTES);
  assign ao_hit     = (win_req.addr[31:12] == mini_mcu_pkg::AO_BASE[31:12]);

  always_comb begin
    ram_req_o      = win_req;
    ram_req_o.req  = win_valid && ram_hit;
    ram_req_o.addr = ram_offset;
    ao_req_o       = win_req;
    ao_req_o.req   = win_valid && ao_hit && !ram_hit;
    ao_req_o.addr  = {20'h0_0000, win_req.addr[11:0]};
  end

  // unmapped accesses are granted by the bus itself
  always_comb begin
    if (ram_hit) begin
      win_gnt = ram_resp_i.gnt;
    end else if (ao_hit) begin
      win_gnt = ao_resp_i.gnt;
    end else begin
      win_gnt = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_q      <= '0;
      rsp_valid_q <= 1'b0;
      rsp_idx_q   <= '0;
      rsp_err_q   <= 1'b0;
    end else begin
      rsp_valid_q <= win_valid && win_gnt;
      if (win_valid && win_gnt) begin
        rsp_idx_q <= win_idx;
        rsp_err_q <= !ram_hit && !ao_hit;
        if (contested) begin
          prio_q <= (win_idx == IDX_W'(NM - 1)) ? '0 : win_idx + 1'b1;
        end
      end
    end
  end

  // only the slave that was addressed raises rvalid
  assign rsp_hit   = rsp_err_q || ram_resp_i.rvalid || ao_resp_i.rvalid;
  assign rsp_rdata = rsp_err_q         ? 32'h0 :
                     ram_resp_i.rvalid ? ram_resp_i.rdata : ao_resp_i.rdata;

  always_comb begin
    for (int m = 0; m < NM; m++) begin
      master_resp_o[m].gnt    = win_valid && win_gnt && (win_idx == IDX_W'(m));
      master_resp_o[m].rvalid = rsp_valid_q && rsp_hit && (rsp_idx_q == IDX_W'(m));
      master_resp_o[m].err    = master_resp_o[m].rvalid && rsp_err_q;
      master_resp_o[m].rdata  = master_resp_o[m].rvalid ? rsp_rdata : 32'h0;
    end
  end

endmodule

`default_nettype wire

// File: mini_mcu_pkg.sv
// ********************
// shared OBI bus types, address map and always-on register offsets
// referenced by scoped name from every module of the fabric
// ********************
`default_nettype none

package mini_mcu_pkg;

  // master request, held stable until gnt
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  // gnt is combinational, rvalid follows one cycle after the handshake
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  // master 0 is the core data port, master 1 the external master
  localparam int unsigned NUM_MASTERS = 2;

  // address map
  localparam logic [31:0] RAM_BASE = 32'h0000_0000;
  localparam logic [31:0] AO_BASE  = 32'h2000_0000;

  // always-on page offsets
  localparam logic [11:0] AO_EXIT_VALID_OFFSET  = 12'h000;
  localparam logic [11:0] AO_EXIT_VALUE_OFFSET  = 12'h004;
  localparam logic [11:0] AO_SCRATCH_OFFSET     = 12'h008;
  localparam logic [11:0] AO_BANK_EN_OFFSET     = 12'h00C;
  localparam logic [11:0] AO_BOOT_SELECT_OFFSET = 12'h010;

  // merge a write word into an old word, one byte lane per be bit
  function automatic logic [31:0] be_merge(
    input logic [31:0] old_word,
    input logic [31:0] new_word,
    input logic [3:0]  be
  );
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  // full word write, all lanes enabled
  localparam logic [3:0] BE_ALL = 4'b1111;

  // idle request, used where no master is selected
  localparam obi_req_t OBI_REQ_IDLE = '{
    req:   1'b0,
    we:    1'b0,
    be:    4'b0000,
    addr:  32'h0000_0000,
    wdata: 32'h0000_0000
  };

endpackage

`default_nettype wire
